// File: files.f
+incdir+common
common/mq_req_pkg.sv
common/mq_rsp_pkg.sv
fifo/fifo.sv
hdl/req_scheduler.sv
hdl/reg_store.sv
hdl/mem_queue_top.sv
test/tb_mem_queue.sv

// File: Bender.yml
package:
  name: mem_queue

dependencies: {}

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mq_req_pkg.sv
      - common/mq_rsp_pkg.sv
      - fifo/fifo.sv
      - hdl/req_scheduler.sv
      - hdl/reg_store.sv
      - hdl/mem_queue_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_mem_queue.sv

// File: test/tb_mem_queue.sv
`timescale 1ns/1ns
`include "mq_config.svh"

module tb_mem_queue;

	localparam int RSPQ_DEPTH  = 1 << `MQ_RSPQ_BITS;
	localparam int STIM_CYCLES = 1 + 16 + 15 + 308;	// Strobe cycles of tests 1, 2, 3 and 5

	logic                          clk;
	logic                          rst;
	logic                          wr_strobe;
	mq_req_pkg::wr_req_t           wr_req;
	logic                          wr_full;
	logic                          wr_almost_full;
	logic                          rd_strobe;
	mq_req_pkg::rd_req_t           rd_req;
	logic                          rd_full;
	logic                          rd_almost_full;
	logic                          rsp_pop;
	mq_rsp_pkg::rsp_t              rsp_data;
	logic                          rsp_empty;
	logic [`MQ_RSPQ_BITS:0]        rsp_count;

	logic [31:0]                   rng_state;	// Xorshift state
	logic [`MQ_DATA_W-1:0]         store_img [`MQ_STORE_WORDS];	// Model of the store
	mq_rsp_pkg::rsp_t              exp_q [$];	// Responses in expected order
	int                            errors;
	int                            checks;
	int                            test_base;	// Error count when the test began
	int                            rd_dropped;	// Read strobes refused by rd_full
	logic                          level_check;	// Test 4 rules active

	mem_queue_top DUT (
		.clk            (clk),
		.rst            (rst),
		.wr_strobe      (wr_strobe),
		.wr_req         (wr_req),
		.wr_full        (wr_full),
		.wr_almost_full (wr_almost_full),
		.rd_strobe      (rd_strobe),
		.rd_req         (rd_req),
		.rd_full        (rd_full),
		.rd_almost_full (rd_almost_full),
		.rsp_pop        (rsp_pop),
		.rsp_data       (rsp_data),
		.rsp_empty      (rsp_empty),
		.rsp_count      (rsp_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	// Watchdog, generous margin over the stimulus length
	initial begin
		repeat (STIM_CYCLES * 8) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not complete", STIM_CYCLES * 8);
		$display("Done: errors found");
		$finish;
	end

	function logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_rsp(input string name, input mq_rsp_pkg::rsp_t got,
			input mq_rsp_pkg::rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [`MQ_RSPQ_BITS:0] got,
			input logic [`MQ_RSPQ_BITS:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Sample one cycle of DUT outputs against the model
	task automatic observe();
		mq_rsp_pkg::rsp_t e;
		int               cap;
		if (wr_strobe && !wr_full)
			store_img[wr_req.addr] = wr_req.data;	// Queue order equals store order
		if (rd_strobe) begin
			if (rd_full) begin
				rd_dropped++;	// Strobe lost on a full queue
			end else begin
				e.addr = rd_req.addr;
				e.data = store_img[rd_req.addr];
				exp_q.push_back(e);
			end
		end
		// Outstanding reads still include the one popped this cycle
		cap = (exp_q.size() < RSPQ_DEPTH) ? exp_q.size() : RSPQ_DEPTH;
		if (rsp_pop && !rsp_empty) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("A response was popped although none was expected");
			end else begin
				check_rsp("rsp_data", rsp_data, exp_q.pop_front());
			end
		end else begin
			check_rsp("rsp_data", rsp_data, '0);	// Show-ahead output idles at zero
		end
		if (level_check && (rsp_count == 3 || rsp_count == 4)) begin
			check_flag("rsp_empty", rsp_empty, 1'b0);
			checks++;
			if (rsp_count > cap) begin
				errors++;
				$display("Response queue holds %0d entries but only %0d can exist", rsp_count, cap);
			end
		end
	endtask

	// Drive one cycle at the rising edge, check at the falling edge
	task automatic step(input logic wr_s, input mq_req_pkg::wr_req_t wq, input logic rd_s,
			input mq_req_pkg::rd_req_t rq, input logic pop);
		@(posedge clk);
		wr_strobe <= wr_s;
		wr_req    <= wq;
		rd_strobe <= rd_s;
		rd_req    <= rq;
		rsp_pop   <= pop;
		@(negedge clk);
		observe();
	endtask

	task automatic idle(input logic pop);
		step(1'b0, '0, 1'b0, '0, pop);
	endtask

	task automatic wait_write_drain();
		int n;
		n = 0;
		while ((wr_almost_full || wr_full) && n < 50) begin
			idle(1'b1);
			n++;
		end
		if (wr_almost_full || wr_full) begin
			errors++;
			$display("The write queue did not drain within 50 cycles");
		end
		repeat (20) idle(1'b1);	// Let the last queued writes reach the store
	endtask

	task automatic wait_responses(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			idle(1'b1);
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected responses never arrived", exp_q.size());
			exp_q.delete();
		end
		repeat (8) idle(1'b1);	// Any extra response shows up here
	endtask

	task automatic report_test(input string name);
		if (errors == test_base)
			$display("%s passed", name);
		else
			$display("%s failed with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		mq_req_pkg::wr_req_t wq;
		mq_req_pkg::rd_req_t rq;
		logic [31:0]         r;
		int                  drops_before;
		rst         = 1'b1;
		wr_strobe   = 1'b0;
		wr_req      = '0;
		rd_strobe   = 1'b0;
		rd_req      = '0;
		rsp_pop     = 1'b0;
		rng_state   = 32'd98;
		errors      = 0;
		checks      = 0;
		test_base   = 0;
		rd_dropped  = 0;
		level_check = 1'b0;
		for (int i = 0; i < `MQ_STORE_WORDS; i++)
			store_img[i] = '0;	// Store clears at reset
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// Test 1, reset state
		@(negedge clk);
		check_flag("rsp_empty", rsp_empty, 1'b1);
		check_count("rsp_count", rsp_count, '0);
		check_flag("wr_full", wr_full, 1'b0);
		check_flag("wr_almost_full", wr_almost_full, 1'b0);
		check_flag("rd_full", rd_full, 1'b0);
		check_flag("rd_almost_full", rd_almost_full, 1'b0);
		check_rsp("rsp_data", rsp_data, '0);
		report_test("test 1 reset state");

		// Test 2, random writes then read back
		for (int i = 0; i < 8; i++) begin
			r       = next_rand();
			wq.addr = r[`MQ_ADDR_W-1:0];
			wq.data = next_rand();
			step(1'b1, wq, 1'b0, '0, 1'b1);
		end
		wait_write_drain();
		for (int i = 0; i < 8; i++) begin
			r       = next_rand();
			rq.addr = r[`MQ_ADDR_W-1:0];	// Unwritten words must read zero
			step(1'b0, '0, 1'b1, rq, 1'b1);
		end
		wait_responses(100);
		report_test("test 2 write then read back");

		// Tests 3 and 4, back-pressure with popping stopped
		level_check = 1'b1;
		for (int i = 0; i < 12; i++) begin
			r       = next_rand();
			rq.addr = r[`MQ_ADDR_W-1:0];
			step(1'b0, '0, 1'b1, rq, 1'b0);
		end
		repeat (10) idle(1'b0);	// Store settles with the response queue full
		check_flag("rd_full", rd_full, 1'b1);
		check_flag("rd_almost_full", rd_almost_full, 1'b1);
		check_count("rsp_count", rsp_count, RSPQ_DEPTH[`MQ_RSPQ_BITS:0]);
		drops_before = rd_dropped;
		for (int i = 0; i < 3; i++) begin
			r       = next_rand();
			rq.addr = r[`MQ_ADDR_W-1:0];
			step(1'b0, '0, 1'b1, rq, 1'b0);
		end
		checks++;
		if (rd_dropped - drops_before != 3) begin
			errors++;
			$display("Read strobes on a full queue were accepted, %0d of 3 dropped",
				rd_dropped - drops_before);
		end
		wait_responses(100);
		level_check = 1'b0;
		report_test("test 3 and 4 full queues and levels");

		// Test 5, preload upper half then mixed traffic on disjoint halves
		for (int i = 8; i < 16; i++) begin
			wq.addr = i[`MQ_ADDR_W-1:0];
			wq.data = next_rand();
			step(1'b1, wq, 1'b0, '0, 1'b1);
		end
		wait_write_drain();
		for (int i = 0; i < 300; i++) begin
			r       = next_rand();
			wq.addr = {1'b0, r[3:1]};	// Writes stay in words 0 to 7
			wq.data = next_rand();
			rq.addr = {1'b1, r[7:5]};	// Reads stay in words 8 to 15
			step(r[0], wq, r[4], rq, r[8] | r[9]);
		end
		wait_responses(200);
		check_flag("rsp_empty", rsp_empty, 1'b1);
		report_test("test 5 mixed random traffic");

		$display("checks: %0d, errors: %0d, read strobes dropped: %0d", checks, errors,
			rd_dropped);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule : tb_mem_queue

// File: hdl/mem_queue_top.sv
`timescale 1ns/1ns
`include "mq_config.svh"

module mem_queue_top (
	input  logic                    clk,
	input  logic                    rst,

	// Write requests
	input  logic                    wr_strobe,
	input  mq_req_pkg::wr_req_t     wr_req,
	output logic                    wr_full,
	output logic                    wr_almost_full,

	// Read requests
	input  logic                    rd_strobe,
	input  mq_req_pkg::rd_req_t     rd_req,
	output logic                    rd_full,
	output logic                    rd_almost_full,

	// Read responses
	input  logic                    rsp_pop,
	output mq_rsp_pkg::rsp_t        rsp_data,	// Zero unless rsp_pop
	output logic                    rsp_empty,
	output logic [`MQ_RSPQ_BITS:0]  rsp_count
);

	// Write queue to scheduler
	mq_req_pkg::wr_req_t   wrq_head;
	logic                  wrq_empty;
	logic                  wrq_pop;

	// Read queue to scheduler
	mq_req_pkg::rd_req_t   rdq_head;
	logic                  rdq_empty;
	logic                  rdq_pop;

	// Response queue level back to scheduler
	logic                  rspq_full;
	logic                  rspq_almost_full;

	// Scheduler to store
	logic                  st_we;
	logic [`MQ_ADDR_W-1:0] st_waddr;
	logic [`MQ_DATA_W-1:0] st_wdata;
	logic                  st_re;
	logic [`MQ_ADDR_W-1:0] st_raddr;

	// Store result into the response queue
	logic                  rd_done;
	mq_rsp_pkg::rsp_t      st_rsp;

	fifo #(
		.BUF_WIDTH (`MQ_WRQ_BITS),
		.payload_t (mq_req_pkg::wr_req_t)
	) u_wr_fifo (
		.clk             (clk),
		.rst             (rst),
		.buf_in          (wr_req),
		.wr_en           (wr_strobe),	// Dropped when full
		.rd_en           (wrq_pop),
		.buf_out         (wrq_head),
		.buf_empty       (wrq_empty),
		.buf_full        (wr_full),
		.buf_almost_full (wr_almost_full),
		.fifo_counter    ()
	);

	fifo #(
		.BUF_WIDTH (`MQ_RDQ_BITS),
		.payload_t (mq_req_pkg::rd_req_t)
	) u_rd_fifo (
		.clk             (clk),
		.rst             (rst),
		.buf_in          (rd_req),
		.wr_en           (rd_strobe),	// Dropped when full
		.rd_en           (rdq_pop),
		.buf_out         (rdq_head),
		.buf_empty       (rdq_empty),
		.buf_full        (rd_full),
		.buf_almost_full (rd_almost_full),
		.fifo_counter    ()
	);

	req_scheduler u_sched (
		.clk              (clk),
		.rst              (rst),
		.wrq_empty        (wrq_empty),
		.wrq_head         (wrq_head),
		.wrq_pop          (wrq_pop),
		.rdq_empty        (rdq_empty),
		.rdq_head         (rdq_head),
		.rdq_pop          (rdq_pop),
		.rspq_full        (rspq_full),
		.rspq_almost_full (rspq_almost_full),
		.st_we            (st_we),
		.st_waddr         (st_waddr),
		.st_wdata         (st_wdata),
		.st_re            (st_re),
		.st_raddr         (st_raddr),
		.rd_done          (rd_done)
	);

	reg_store u_store (
		.clk     (clk),
		.rst     (rst),
		.we      (st_we),
		.waddr   (st_waddr),
		.wdata   (st_wdata),
		.re      (st_re),
		.raddr   (st_raddr),
		.rd_done (rd_done),
		.rsp     (st_rsp)
	);

	fifo #(
		.BUF_WIDTH (`MQ_RSPQ_BITS),
		.payload_t (mq_rsp_pkg::rsp_t)
	) u_rsp_fifo (
		.clk             (clk),
		.rst             (rst),
		.buf_in          (st_rsp),
		.wr_en           (rd_done),	// Slot already reserved by scheduler
		.rd_en           (rsp_pop),
		.buf_out         (rsp_data),
		.buf_empty       (rsp_empty),
		.buf_full        (rspq_full),
		.buf_almost_full (rspq_almost_full),
		.fifo_counter    (rsp_count)
	);

endmodule : mem_queue_top

// File: hdl/reg_store.sv
`timescale 1ns/1ns
`include "mq_config.svh"

module reg_store (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  we,	// Write strobe
	input  logic [`MQ_ADDR_W-1:0] waddr,
	input  logic [`MQ_DATA_W-1:0] wdata,
	input  logic                  re,	// Read strobe
	input  logic [`MQ_ADDR_W-1:0] raddr,
	output logic                  rd_done,	// One cycle after re
	output mq_rsp_pkg::rsp_t      rsp	// Address and data of the read
);

	logic [`MQ_DATA_W-1:0] mem [`MQ_STORE_WORDS];

	// Word array, all zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MQ_STORE_WORDS; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, old data on a same-word write
	always_ff @(posedge clk) begin
		if (re) begin
			rsp.addr <= raddr;	// Echo address for the response
			rsp.data <= mem[raddr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_done <= 1'b0;
		else
			rd_done <= re;	// Single-cycle completion pulse
	end

endmodule : reg_store

// File: hdl/req_scheduler.sv
`timescale 1ns/1ns
`include "mq_config.svh"

module req_scheduler (
	input  logic                  clk,
	input  logic                  rst,

	// Write request queue
	input  logic                  wrq_empty,
	input  mq_req_pkg::wr_req_t   wrq_head,	// Valid only in the pop cycle
	output logic                  wrq_pop,

	// Read request queue
	input  logic                  rdq_empty,
	input  mq_req_pkg::rd_req_t   rdq_head,	// Valid only in the pop cycle
	output logic                  rdq_pop,

	// Response queue level, used to reserve a slot per read
	input  logic                  rspq_full,
	input  logic                  rspq_almost_full,

	// Store write port
	output logic                  st_we,
	output logic [`MQ_ADDR_W-1:0] st_waddr,
	output logic [`MQ_DATA_W-1:0] st_wdata,

	// Store read port
	output logic                  st_re,
	output logic [`MQ_ADDR_W-1:0] st_raddr,
	input  logic                  rd_done	// Store result ready this cycle
);

	mq_rsp_pkg::grant_t last_grant;	// Queue served most recently
	logic               rd_inflight;	// A read sits in the store, not yet in the queue
	logic               wr_ok;	// Write queue can be served
	logic               rd_ok;	// Read queue can be served
	logic               pick_rd;	// Read wins this cycle

	// Eligibility of each queue
	always_comb begin
		wr_ok = !wrq_empty;
		// A read needs a free slot in the response queue.
		// The count does not yet include a read still inside the store,
		// so an almost full queue only accepts if nothing is in flight.
		rd_ok = !rdq_empty
			&& !rspq_full
			&& !(rspq_almost_full && rd_inflight);
	end

	// Round-robin choice, one pop per cycle
	always_comb begin
		if (wr_ok && rd_ok)
			pick_rd = (last_grant == mq_rsp_pkg::WR);	// Alternate on contention
		else
			pick_rd = rd_ok;	// Single candidate wins
	end

	always_comb begin
		wrq_pop = wr_ok && !pick_rd;
		rdq_pop = rd_ok && pick_rd;
	end

	// Popped request becomes a store command in the same cycle
	always_comb begin
		st_we    = wrq_pop;
		st_waddr = wrq_head.addr;	// Head is zero outside a pop
		st_wdata = wrq_head.data;
		st_re    = rdq_pop;
		st_raddr = rdq_head.addr;
	end

	// Grant history for the round robin
	always_ff @(posedge clk) begin
		if (rst)
			last_grant <= mq_rsp_pkg::NONE;
		else if (wrq_pop)
			last_grant <= mq_rsp_pkg::WR;
		else if (rdq_pop)
			last_grant <= mq_rsp_pkg::RD;
	end

	// In-flight read tracking
	// A new issue takes priority over the completion of the previous one,
	// since back-to-back reads overlap by one cycle
	always_ff @(posedge clk) begin
		if (rst)
			rd_inflight <= 1'b0;
		else if (rdq_pop)
			rd_inflight <= 1'b1;	// Issued, result arrives next cycle
		else if (rd_done)
			rd_inflight <= 1'b0;	// Result is now counted by the queue
	end

endmodule : req_scheduler

// File: fifo/fifo.sv
`timescale 1ns/1ns

module fifo #(
	parameter      BUF_WIDTH = 3,	// 2**BUF_WIDTH entries
	parameter type payload_t = logic [31:0]	// Entry type
) (
	input  logic                 clk,
	input  logic                 rst,
	input  payload_t             buf_in,	// Data to push
	input  logic                 wr_en,	// Push strobe
	input  logic                 rd_en,	// Pop strobe
	output payload_t             buf_out,	// Head entry, zero unless popping
	output logic                 buf_empty,
	output logic                 buf_full,
	output logic                 buf_almost_full,
	output logic [BUF_WIDTH:0]   fifo_counter	// Entries held
);

	localparam int BUF_SIZE = 1 << BUF_WIDTH;

	logic [BUF_WIDTH-1:0] rd_ptr;	// Next entry to pop
	logic [BUF_WIDTH-1:0] wr_ptr;	// Next free slot
	logic                 do_wr;	// Push accepted this cycle
	logic                 do_rd;	// Pop accepted this cycle
	payload_t             buf_mem [BUF_SIZE];

	// Flags come straight from the occupancy count
	always_comb begin
		buf_empty       = (fifo_counter == '0);
		buf_full        = (fifo_counter == BUF_SIZE[BUF_WIDTH:0]);
		buf_almost_full = (fifo_counter == BUF_SIZE[BUF_WIDTH:0] - 1'b1) || buf_full;
	end

	always_comb begin
		do_wr = wr_en && !buf_full;	// Push on a full buffer is dropped
		do_rd = rd_en && !buf_empty;	// Pop on an empty buffer is ignored
	end

	// Occupancy counter
	always_ff @(posedge clk) begin
		if (rst)
			fifo_counter <= '0;
		else if (do_wr && !do_rd)
			fifo_counter <= fifo_counter + 1'b1;
		else if (do_rd && !do_wr)
			fifo_counter <= fifo_counter - 1'b1;
		// Push and pop together leave the count unchanged
	end

	// Show-ahead read, head is only presented in the pop cycle
	always_comb begin
		if (do_rd)
			buf_out = buf_mem[rd_ptr];
		else
			buf_out = '0;
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			buf_mem[wr_ptr] <= buf_in;
	end

	// Pointers wrap naturally at BUF_SIZE
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule : fifo

// File: common/mq_rsp_pkg.sv
`include "mq_config.svh"

package mq_rsp_pkg;

	// Completed read, address echoed with the data
	typedef struct packed {
		logic [`MQ_ADDR_W-1:0] addr;	// Word that was read
		logic [`MQ_DATA_W-1:0] data;	// Contents at read time
	} rsp_t;

	// Last queue served by the scheduler
	typedef enum logic [1:0] {
		NONE = 2'd0,	// Nothing served since reset
		WR   = 2'd1,	// Write queue
		RD   = 2'd2	// Read queue
	} grant_t;

endpackage : mq_rsp_pkg

// File: common/mq_req_pkg.sv
`include "mq_config.svh"

package mq_req_pkg;

	// Write request as it sits in the write queue
	typedef struct packed {
		logic [`MQ_ADDR_W-1:0] addr;	// Target word
		logic [`MQ_DATA_W-1:0] data;	// Value to store
	} wr_req_t;

	// Read request, address only
	typedef struct packed {
		logic [`MQ_ADDR_W-1:0] addr;	// Word to fetch
	} rd_req_t;

endpackage : mq_req_pkg

// File: common/mq_config.svh
`ifndef MQ_CONFIG_SVH
`define MQ_CONFIG_SVH

// Word address into the register store
`define MQ_ADDR_W 4

// Payload width of one store word
`define MQ_DATA_W 32

// Store size, must match 2**MQ_ADDR_W
`define MQ_STORE_WORDS 16

// Queue depths as log2 of the entry count
`define MQ_WRQ_BITS 3	// 8 write requests
`define MQ_RDQ_BITS 3	// 8 read requests
`define MQ_RSPQ_BITS 2	// 4 read responses

`endif
